// ==== list.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_fxarb.sv
verilog/dcache_mem_req_read_arbiter.sv
verilog/dcache_miss_req.sv
verilog/dcache_uncached_req.sv
verilog/dcache_prefetch_req.sv
verilog/dcache_mem_read_top.sv
testbench/tb_dcache_mem_read.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing -sv
LINT_FLAGS := --lint-only --timing -sv
TOP        := tb_dcache_mem_read
RTL_TOP    := dcache_mem_read_top
FILELIST   := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_dcache_mem_read.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defines.svh"

module tb_dcache_mem_read
import dcache_pkg::*;
();

    // ======================================================================
    // Stimulus table
    // ======================================================================
    localparam logic [3:0] OP_IDLE  = 4'd0;             // Wait a cycles.
    localparam logic [3:0] OP_HOLD  = 4'd1;             // Ready low for a cycles.
    localparam logic [3:0] OP_MISS  = 4'd2;             // Address a, MSHR b.
    localparam logic [3:0] OP_UC    = 4'd3;             // Address a.
    localparam logic [3:0] OP_PF    = 4'd4;             // Base a, stride b, count c.
    localparam logic [3:0] OP_FULL  = 4'd5;             // Miss FIFO must be full.
    localparam logic [3:0] OP_MARK  = 4'd6;             // Start of the priority case.
    localparam logic [3:0] OP_ORDER = 4'd7;             // Check accepted order.
    localparam int         NUM_STEPS = 28;

    typedef struct packed {
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  c;
    } step_t;

    typedef struct packed {
        mem_id_t   id;
        mem_addr_t addr;
    } exp_t;

    logic       clk_i = 1'b0;
    logic       arst_n_i;
    logic       miss_valid_i, uc_valid_i, pf_start_i, mem_req_read_ready_i;
    mem_addr_t  miss_addr_i, uc_addr_i, pf_base_i, pf_stride_i;
    mshr_idx_t  miss_mshr_i;
    logic [3:0] pf_count_i;
    logic       miss_ready_o, uc_ready_o, pf_busy_o, mem_req_read_valid_o;
    mem_addr_t  mem_req_read_addr_o;
    mem_id_t    mem_req_read_id_o;
    mem_len_t   mem_req_read_len_o;

    step_t      steps [NUM_STEPS];
    exp_t       exp_miss [$];                           // Ids 0 to 7.
    exp_t       exp_uc [$];                             // Ids 8 to 11.
    exp_t       exp_pf [$];                             // Ids 12 to 15.
    int         accepted_src [$];                       // 0 miss, 1 uncached, 2 prefetch.
    int         cycle = 0;
    int         limit;
    int         hold_until = 0;
    int         order_mark = 0;
    int         uc_issued = 0;
    int         value_errors = 0;
    int         other_errors = 0;
    logic       busy_chk = 1'b0;                        // Prefetcher must be idle now.
    logic       stalled = 1'b0;
    mem_addr_t  stall_addr;
    mem_id_t    stall_id;
    mem_len_t   stall_len;

    dcache_mem_read_top dcache_mem_read_top_i (.*);

    always #20 clk_i = ~clk_i;                          // 40 ns period.

    function automatic mem_addr_t line_align(input mem_addr_t a);
        return a & ~mem_addr_t'(`DCACHE_LINE_BYTES - 1);
    endfunction

    function automatic int step_cycles(input step_t st);
        if ((st.op == OP_IDLE) || (st.op == OP_HOLD)) return int'(st.a);
        if ((st.op == OP_MISS) || (st.op == OP_UC) || (st.op == OP_PF)) return 4;
        return 2;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        value_errors++;
        $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic report_event(input string msg);
        other_errors++;
        $display("failure at cycle %0d: %s", cycle, msg);
    endtask

    task automatic load_steps();
        steps[0]  = '{OP_IDLE,  32'd2,          32'd0,          4'd0};
        steps[1]  = '{OP_MISS,  32'h0000_1234,  32'd3,          4'd0};
        steps[2]  = '{OP_MISS,  32'h0000_2048,  32'd5,          4'd0};
        steps[3]  = '{OP_UC,    32'h8000_0013,  32'd0,          4'd0};
        steps[4]  = '{OP_UC,    32'h8000_0106,  32'd0,          4'd0};
        steps[5]  = '{OP_UC,    32'h8000_0203,  32'd0,          4'd0};
        steps[6]  = '{OP_UC,    32'h8000_0301,  32'd0,          4'd0};
        steps[7]  = '{OP_UC,    32'h8000_0407,  32'd0,          4'd0};  // Id wraps to 8.
        steps[8]  = '{OP_IDLE,  32'd20,         32'd0,          4'd0};
        steps[9]  = '{OP_HOLD,  32'd10,         32'd0,          4'd0};
        steps[10] = '{OP_MISS,  32'h1000_0044,  32'd1,          4'd0};
        steps[11] = '{OP_MISS,  32'h1000_0088,  32'd6,          4'd0};
        steps[12] = '{OP_FULL,  32'd0,          32'd0,          4'd0};
        steps[13] = '{OP_IDLE,  32'd30,         32'd0,          4'd0};
        steps[14] = '{OP_PF,    32'h2000_0010,  32'h0000_0040,  4'd5};
        steps[15] = '{OP_PF,    32'h3000_0000,  32'h0000_0020,  4'd2};  // Dropped while busy.
        steps[16] = '{OP_IDLE,  32'd40,         32'd0,          4'd0};
        steps[17] = '{OP_PF,    32'h4000_0000,  32'h0000_0020,  4'd0};  // Empty burst.
        steps[18] = '{OP_IDLE,  32'd4,          32'd0,          4'd0};
        steps[19] = '{OP_MARK,  32'd0,          32'd0,          4'd0};
        steps[20] = '{OP_HOLD,  32'd12,         32'd0,          4'd0};
        steps[21] = '{OP_PF,    32'h5000_0003,  32'h0000_0024,  4'd3};
        steps[22] = '{OP_MISS,  32'h6000_007c,  32'd2,          4'd0};
        steps[23] = '{OP_UC,    32'h7000_0002,  32'd0,          4'd0};
        steps[24] = '{OP_IDLE,  32'd40,         32'd0,          4'd0};
        steps[25] = '{OP_ORDER, 32'd0,          32'd0,          4'd0};
        steps[26] = '{OP_PF,    32'h0000_0100,  32'hffff_ffe0,  4'd2};  // Walks down.
        steps[27] = '{OP_IDLE,  32'd30,         32'd0,          4'd0};
    endtask

    // ======================================================================
    // Source drivers with the reference model
    // ======================================================================
    task automatic push_miss(input mem_addr_t addr, input mshr_idx_t mshr);
        @(posedge clk_i);
        miss_valid_i <= 1'b1;
        miss_addr_i  <= addr;
        miss_mshr_i  <= mshr;
        @(negedge clk_i);
        while (!miss_ready_o) @(negedge clk_i);         // Accepted on next edge.
        @(posedge clk_i);
        miss_valid_i <= 1'b0;
        exp_miss.push_back('{id: mem_id_t'(mshr), addr: line_align(addr)});
    endtask

    task automatic push_uncached(input mem_addr_t addr);
        @(posedge clk_i);
        uc_valid_i <= 1'b1;
        uc_addr_i  <= addr;
        @(negedge clk_i);
        while (!uc_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        uc_valid_i <= 1'b0;
        exp_uc.push_back('{id: mem_id_t'(`DCACHE_UC_ID_BASE + (uc_issued % 4)),
                           addr: addr & ~mem_addr_t'(`DCACHE_WORD_BYTES - 1)});
        uc_issued++;
    endtask

    task automatic start_prefetch(input mem_addr_t base, input mem_addr_t stride,
                                  input logic [3:0] count);
        logic was_busy;
        @(posedge clk_i);
        pf_start_i  <= 1'b1;
        pf_base_i   <= base;
        pf_stride_i <= stride;
        pf_count_i  <= count;
        @(posedge clk_i);
        was_busy = (exp_pf.size() != 0) || busy_chk;    // Last transfer not yet done.
        pf_start_i <= 1'b0;
        if (!was_busy && (count != 4'd0)) begin
            for (int k = 0; k < int'(count); k++) begin
                exp_pf.push_back('{id: mem_id_t'(`DCACHE_PF_ID_BASE + (k % 4)),
                                   addr: line_align(base + mem_addr_t'(k) * stride)});
            end
            @(negedge clk_i);
            if (pf_busy_o !== 1'b1) report_value("pf_busy_o", 32'(pf_busy_o), 32'd1);
        end
    endtask

    task automatic check_order();
        int exp_src [4];
        exp_src = '{2, 0, 1, 2};                        // Locked prefetch goes first.
        @(negedge clk_i);
        if (accepted_src.size() < order_mark + 4) begin
            report_event("too few requests accepted in the priority case");
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (accepted_src[order_mark + i] != exp_src[i]) begin
                    report_value("mem_req_read_id_o source", 32'(accepted_src[order_mark + i]),
                                 32'(exp_src[i]));
                end
            end
        end
    endtask

    task automatic run_step(input step_t st);
        case (st.op)
            OP_IDLE:  repeat (int'(st.a)) @(posedge clk_i);
            OP_HOLD: begin
                @(posedge clk_i);
                hold_until <= cycle + int'(st.a);       // Sink holds ready low.
            end
            OP_MISS:  push_miss(st.a, mshr_idx_t'(st.b));
            OP_UC:    push_uncached(st.a);
            OP_PF:    start_prefetch(st.a, st.b, st.c);
            OP_FULL: begin
                @(posedge clk_i);
                @(negedge clk_i);
                if (miss_ready_o !== 1'b0) begin
                    report_value("miss_ready_o", 32'(miss_ready_o), 32'd0);
                end
            end
            OP_MARK: begin
                @(posedge clk_i);
                order_mark = accepted_src.size();
            end
            OP_ORDER: check_order();
            default:  report_event("unknown table operation");
        endcase
    endtask

    // ======================================================================
    // Memory sink, channel checks and timeout
    // ======================================================================
    always @(posedge clk_i) begin
        logic [31:0] rnd;
        rnd = $urandom;
        cycle <= cycle + 1;
        if (cycle < hold_until) mem_req_read_ready_i <= 1'b0;
        else mem_req_read_ready_i <= rnd[0];
    end

    always @(negedge clk_i) begin
        exp_t     head;
        logic     found;
        int       src;
        mem_len_t exp_len;
        if (arst_n_i) begin
            if (busy_chk && (pf_busy_o !== 1'b0)) begin
                report_value("pf_busy_o", 32'(pf_busy_o), 32'd0);
            end
            busy_chk = 1'b0;
            if (stalled) begin                          // Fields frozen under back-pressure.
                if (mem_req_read_valid_o !== 1'b1) report_event("valid dropped while stalled");
                if (mem_req_read_addr_o !== stall_addr) begin
                    report_value("mem_req_read_addr_o", mem_req_read_addr_o, stall_addr);
                end
                if (mem_req_read_id_o !== stall_id) begin
                    report_value("mem_req_read_id_o", 32'(mem_req_read_id_o), 32'(stall_id));
                end
                if (mem_req_read_len_o !== stall_len) begin
                    report_value("mem_req_read_len_o", 32'(mem_req_read_len_o), 32'(stall_len));
                end
            end
            stalled    = mem_req_read_valid_o && !mem_req_read_ready_i;
            stall_addr = mem_req_read_addr_o;
            stall_id   = mem_req_read_id_o;
            stall_len  = mem_req_read_len_o;
            if (mem_req_read_valid_o && mem_req_read_ready_i) begin
                found   = 1'b0;
                exp_len = mem_len_t'(`DCACHE_LINE_LEN);
                if (mem_req_read_id_o < mem_id_t'(`DCACHE_UC_ID_BASE)) src = 0;
                else if (mem_req_read_id_o < mem_id_t'(`DCACHE_PF_ID_BASE)) src = 1;
                else src = 2;
                accepted_src.push_back(src);
                case (src)
                    0: if (exp_miss.size() != 0) begin
                        head  = exp_miss.pop_front();
                        found = 1'b1;
                    end
                    1: if (exp_uc.size() != 0) begin
                        head  = exp_uc.pop_front();
                        found = 1'b1;
                    end
                    default: if (exp_pf.size() != 0) begin
                        head  = exp_pf.pop_front();
                        found = 1'b1;
                    end
                endcase
                if (src == 1) exp_len = '0;             // Single word.
                if (!found) begin
                    report_event("request accepted with nothing expected in its id range");
                end else begin
                    if (mem_req_read_addr_o !== head.addr) begin
                        report_value("mem_req_read_addr_o", mem_req_read_addr_o, head.addr);
                    end
                    if (mem_req_read_id_o !== head.id) begin
                        report_value("mem_req_read_id_o", 32'(mem_req_read_id_o), 32'(head.id));
                    end
                    if (mem_req_read_len_o !== exp_len) begin
                        report_value("mem_req_read_len_o", 32'(mem_req_read_len_o), 32'(exp_len));
                    end
                end
                if ((src == 2) && (exp_pf.size() == 0)) busy_chk = 1'b1;  // Burst done.
            end
        end
    end

    always @(posedge clk_i) begin
        if (cycle >= limit) begin
            $display("timeout at cycle %0d, value errors %0d, other errors %0d",
                     cycle, value_errors, other_errors);
            $display("Finished with errors");
            $finish;
        end
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        int total;
        void'($urandom(32'h66ee912d));
        arst_n_i             = 1'b0;
        miss_valid_i         = 1'b0;
        miss_addr_i          = '0;
        miss_mshr_i          = '0;
        uc_valid_i           = 1'b0;
        uc_addr_i            = '0;
        pf_start_i           = 1'b0;
        pf_base_i            = '0;
        pf_stride_i          = '0;
        pf_count_i           = '0;
        mem_req_read_ready_i = 1'b0;
        load_steps();
        total = 4;                                      // Reset cycles.
        foreach (steps[i]) total += step_cycles(steps[i]);
        limit = 2 * total + 200;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        if (mem_req_read_valid_o !== 1'b0) begin
            report_value("mem_req_read_valid_o", 32'(mem_req_read_valid_o), 32'd0);
        end
        if (pf_busy_o !== 1'b0) report_value("pf_busy_o", 32'(pf_busy_o), 32'd0);
        if (miss_ready_o !== 1'b1) report_value("miss_ready_o", 32'(miss_ready_o), 32'd1);
        if (uc_ready_o !== 1'b1) report_value("uc_ready_o", 32'(uc_ready_o), 32'd1);
        foreach (steps[i]) run_step(steps[i]);
        while ((exp_miss.size() + exp_uc.size() + exp_pf.size()) != 0) @(negedge clk_i);
        @(negedge clk_i);                               // Last busy check.
        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if ((value_errors + other_errors) == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_mem_read_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_mem_read_top
import dcache_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       arst_n_i,

    input  wire logic       miss_valid_i,           // Refill side.
    output logic            miss_ready_o,
    input  wire mem_addr_t  miss_addr_i,
    input  wire mshr_idx_t  miss_mshr_i,

    input  wire logic       uc_valid_i,             // Uncached side.
    output logic            uc_ready_o,
    input  wire mem_addr_t  uc_addr_i,

    input  wire logic       pf_start_i,             // Prefetch side.
    input  wire mem_addr_t  pf_base_i,
    input  wire mem_addr_t  pf_stride_i,
    input  wire logic [3:0] pf_count_i,
    output logic            pf_busy_o,

    input  wire logic       mem_req_read_ready_i,   // Memory channel.
    output logic            mem_req_read_valid_o,
    output mem_addr_t       mem_req_read_addr_o,
    output mem_id_t         mem_req_read_id_o,
    output mem_len_t        mem_req_read_len_o
);

    // Port 0 miss, 1 uncached, 2 prefetch.
    logic      src_valid [`DCACHE_MEM_PORTS];
    logic      src_ready [`DCACHE_MEM_PORTS];
    mem_addr_t src_addr  [`DCACHE_MEM_PORTS];
    mem_id_t   src_id    [`DCACHE_MEM_PORTS];
    mem_len_t  src_len   [`DCACHE_MEM_PORTS];

    // ======================================================================
    // Request sources
    // ======================================================================
    dcache_miss_req dcache_miss_req_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .miss_valid_i (miss_valid_i),
        .miss_ready_o (miss_ready_o),
        .miss_addr_i  (miss_addr_i),
        .miss_mshr_i  (miss_mshr_i),
        .req_valid_o  (src_valid[0]),
        .req_ready_i  (src_ready[0]),
        .req_addr_o   (src_addr[0]),
        .req_id_o     (src_id[0]),
        .req_len_o    (src_len[0])
    );

    dcache_uncached_req dcache_uncached_req_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .uc_valid_i  (uc_valid_i),
        .uc_ready_o  (uc_ready_o),
        .uc_addr_i   (uc_addr_i),
        .req_valid_o (src_valid[1]),
        .req_ready_i (src_ready[1]),
        .req_addr_o  (src_addr[1]),
        .req_id_o    (src_id[1]),
        .req_len_o   (src_len[1])
    );

    dcache_prefetch_req dcache_prefetch_req_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .pf_start_i  (pf_start_i),
        .pf_base_i   (pf_base_i),
        .pf_stride_i (pf_stride_i),
        .pf_count_i  (pf_count_i),
        .pf_busy_o   (pf_busy_o),
        .req_valid_o (src_valid[2]),
        .req_ready_i (src_ready[2]),
        .req_addr_o  (src_addr[2]),
        .req_id_o    (src_id[2]),
        .req_len_o   (src_len[2])
    );

    // ======================================================================
    // Channel arbiter
    // ======================================================================
    dcache_mem_req_read_arbiter #(
        .N                    (`DCACHE_MEM_PORTS)
    ) dcache_mem_req_read_arbiter_i (
        .clk_i                (clk_i),
        .arst_n_i             (arst_n_i),
        .req_valid_i          (src_valid),
        .req_ready_o          (src_ready),
        .req_addr_i           (src_addr),
        .req_id_i             (src_id),
        .req_len_i            (src_len),
        .mem_req_read_ready_i (mem_req_read_ready_i),
        .mem_req_read_valid_o (mem_req_read_valid_o),
        .mem_req_read_addr_o  (mem_req_read_addr_o),
        .mem_req_read_id_o    (mem_req_read_id_o),
        .mem_req_read_len_o   (mem_req_read_len_o)
    );

endmodule

`default_nettype wire

// ==== verilog/dcache_prefetch_req.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_prefetch_req
import dcache_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       arst_n_i,

    input  wire logic       pf_start_i,             // Burst trigger.
    input  wire mem_addr_t  pf_base_i,              // First address.
    input  wire mem_addr_t  pf_stride_i,            // Step in bytes.
    input  wire logic [3:0] pf_count_i,             // Number of lines.
    output logic            pf_busy_o,

    output logic            req_valid_o,
    input  wire logic       req_ready_i,
    output mem_addr_t       req_addr_o,
    output mem_id_t         req_id_o,
    output mem_len_t        req_len_o
);

    localparam mem_addr_t LINE_MASK = ~mem_addr_t'(`DCACHE_LINE_BYTES - 1);

    pf_state_t  state_q;
    mem_addr_t  addr_q;                             // base + k*stride.
    mem_addr_t  stride_q;
    logic [3:0] remain_q;                           // Requests left.
    logic [1:0] idx_q;                              // Low bits of k.
    logic       xfer;

    assign xfer        = req_valid_o & req_ready_i;
    assign pf_busy_o   = (state_q == RUN);
    assign req_valid_o = (state_q == RUN);
    assign req_addr_o  = addr_q & LINE_MASK;        // Align each step.
    assign req_id_o    = mem_id_t'(`DCACHE_PF_ID_BASE) + mem_id_t'(idx_q);
    assign req_len_o   = mem_len_t'(`DCACHE_LINE_LEN);

    // ======================================================================
    // Burst sequencer
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= IDLE;
            remain_q <= 4'd0;
            idx_q    <= 2'd0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (pf_start_i && (pf_count_i != 4'd0)) begin
                        state_q  <= RUN;            // Empty burst is ignored.
                        remain_q <= pf_count_i;
                        idx_q    <= 2'd0;
                    end
                end
                RUN: begin
                    if (xfer) begin
                        remain_q <= remain_q - 4'd1;
                        idx_q    <= idx_q + 2'd1;
                        if (remain_q == 4'd1) begin
                            state_q <= IDLE;        // Last one accepted.
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Address walk.
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && pf_start_i) begin
            addr_q   <= pf_base_i;
            stride_q <= pf_stride_i;
        end else if (xfer) begin
            addr_q <= addr_q + stride_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_uncached_req.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_uncached_req
import dcache_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,

    input  wire logic      uc_valid_i,              // Uncached load.
    output logic           uc_ready_o,              // Register is empty.
    input  wire mem_addr_t uc_addr_i,

    output logic           req_valid_o,
    input  wire logic      req_ready_i,
    output mem_addr_t      req_addr_o,
    output mem_id_t        req_id_o,
    output mem_len_t       req_len_o
);

    localparam mem_addr_t WORD_MASK = ~mem_addr_t'(`DCACHE_WORD_BYTES - 1);

    logic       pend_q;                             // Request outstanding.
    mem_addr_t  addr_q;                             // Word address.
    logic [1:0] id_cnt_q;                           // Rotating id offset.

    assign uc_ready_o  = ~pend_q;
    assign req_valid_o = pend_q;
    assign req_addr_o  = addr_q;
    assign req_id_o    = mem_id_t'(`DCACHE_UC_ID_BASE) + mem_id_t'(id_cnt_q);
    assign req_len_o   = '0;                        // Single beat.

    always_ff @(posedge clk_i) begin
        if (uc_valid_i && !pend_q) begin
            addr_q <= uc_addr_i & WORD_MASK;        // Drop byte offset.
        end
    end

    // ======================================================================
    // Pending flag and id counter
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q   <= 1'b0;
            id_cnt_q <= 2'd0;
        end else begin
            if (uc_valid_i && !pend_q) begin
                pend_q <= 1'b1;                     // Captured.
            end else if (pend_q && req_ready_i) begin
                pend_q   <= 1'b0;                   // Sent to memory.
                id_cnt_q <= id_cnt_q + 2'd1;        // Next id in 8 to 11.
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_miss_req.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_miss_req
import dcache_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,

    input  wire logic      miss_valid_i,            // Refill request.
    output logic           miss_ready_o,            // FIFO has room.
    input  wire mem_addr_t miss_addr_i,             // Missing byte address.
    input  wire mshr_idx_t miss_mshr_i,             // Owning MSHR.

    output logic           req_valid_o,
    input  wire logic      req_ready_i,
    output mem_addr_t      req_addr_o,
    output mem_id_t        req_id_o,
    output mem_len_t       req_len_o
);

    localparam mem_addr_t LINE_MASK = ~mem_addr_t'(`DCACHE_LINE_BYTES - 1);

    mem_addr_t   fifo_addr_q [2];                   // Line addresses.
    mshr_idx_t   fifo_mshr_q [2];                   // MSHR indexes.
    logic        wr_ptr_q;                          // Next free slot.
    logic        rd_ptr_q;                          // Head slot.
    logic [1:0]  count_q;                           // Occupancy 0 to 2.
    logic        push;
    logic        pop;

    assign miss_ready_o = (count_q != 2'd2);
    assign req_valid_o  = (count_q != 2'd0);
    assign push         = miss_valid_i & miss_ready_o;
    assign pop          = req_valid_o & req_ready_i;

    // Head entry goes straight out.
    assign req_addr_o = fifo_addr_q[rd_ptr_q];
    assign req_id_o   = mem_id_t'(fifo_mshr_q[rd_ptr_q]);  // Id is the MSHR slot.
    assign req_len_o  = mem_len_t'(`DCACHE_LINE_LEN);      // Full line.

    // ======================================================================
    // Storage
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_addr_q[wr_ptr_q] <= miss_addr_i & LINE_MASK;  // Line aligned.
            fifo_mshr_q[wr_ptr_q] <= miss_mshr_i;
        end
    end

    // ======================================================================
    // Pointers and count
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;        // Both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_mem_req_read_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_mem_req_read_arbiter
import dcache_pkg::*;
#(
    parameter int unsigned N = `DCACHE_MEM_PORTS
)
(
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,

    input  wire logic      req_valid_i [N],         // Source valids.
    output logic           req_ready_o [N],         // Source readies.
    input  wire mem_addr_t req_addr_i  [N],
    input  wire mem_id_t   req_id_i    [N],
    input  wire mem_len_t  req_len_i   [N],

    input  wire logic      mem_req_read_ready_i,    // From memory.
    output logic           mem_req_read_valid_o,
    output mem_addr_t      mem_req_read_addr_o,
    output mem_id_t        mem_req_read_id_o,
    output mem_len_t       mem_req_read_len_o
);

    logic [N-1:0] valid_vec;                        // Packed valids.
    logic [N-1:0] gnt;                              // One-hot grant.

    genvar gen_i;

    // Pack valids and return ready to the granted port.
    generate
        for (gen_i = 0; gen_i < int'(N); gen_i++) begin : port_gen
            assign valid_vec[gen_i]   = req_valid_i[gen_i];
            assign req_ready_o[gen_i] = mem_req_read_ready_i & gnt[gen_i] &
                                        valid_vec[gen_i];
        end
    endgenerate

    dcache_fxarb #(
        .N        (N)
    ) dcache_fxarb_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (valid_vec),
        .ready_i  (mem_req_read_ready_i),
        .gnt_o    (gnt)
    );

    assign mem_req_read_valid_o = |(gnt & valid_vec);   // No grant without valid.

    // ======================================================================
    // One-hot AND-OR field multiplexer
    // ======================================================================
    always_comb begin
        mem_req_read_addr_o = '0;
        mem_req_read_id_o   = '0;
        mem_req_read_len_o  = '0;
        for (int unsigned i = 0; i < N; i++) begin
            if (gnt[i]) begin
                mem_req_read_addr_o = mem_req_read_addr_o | req_addr_i[i];
                mem_req_read_id_o   = mem_req_read_id_o   | req_id_i[i];
                mem_req_read_len_o  = mem_req_read_len_o  | req_len_i[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_fxarb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_fxarb
#(
    parameter int unsigned N = `DCACHE_MEM_PORTS
)
(
    input  wire logic         clk_i,
    input  wire logic         arst_n_i,
    input  wire logic [N-1:0] req_i,                // Valid per port.
    input  wire logic         ready_i,              // Downstream ready.
    output logic      [N-1:0] gnt_o                 // One-hot grant.
);

    logic [N-1:0] pick;                             // Priority winner.
    logic [N-1:0] gnt_q;                            // Grant held under stall.
    logic         lock_q;                           // Grant is frozen.

    // Lowest index wins.
    always_comb begin
        pick = '0;
        for (int unsigned i = 0; i < N; i++) begin
            if (req_i[i] && (pick == '0)) begin
                pick[i] = 1'b1;                     // First set bit only.
            end
        end
    end

    assign gnt_o = lock_q ? gnt_q : pick;           // Held grant beats new pick.

    // ======================================================================
    // Grant lock
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lock_q <= 1'b0;
            gnt_q  <= '0;
        end else begin
            lock_q <= (|(gnt_o & req_i)) & ~ready_i;  // Stalled grant stays.
            if ((|(gnt_o & req_i)) && !ready_i) begin
                gnt_q <= gnt_o;                     // Remember who was granted.
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

    // ======================================================================
    // Request field types
    // ======================================================================
    typedef logic [`DCACHE_ADDR_W-1:0] mem_addr_t;     // Byte address.
    typedef logic [`DCACHE_ID_W-1:0]   mem_id_t;       // Request id.
    typedef logic [`DCACHE_LEN_W-1:0]  mem_len_t;      // Beat count minus one.
    typedef logic [`DCACHE_MSHR_W-1:0] mshr_idx_t;     // MSHR slot.

    // Prefetcher sequencing.
    typedef enum logic {
        IDLE,                                       // Waiting for a start pulse.
        RUN                                         // Issuing the burst.
    } pf_state_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// ==========================================================================
// Memory read request channel widths
// ==========================================================================
`define DCACHE_ADDR_W       32              // Byte address.
`define DCACHE_ID_W         4               // Transaction id.
`define DCACHE_LEN_W        3               // Beats minus one.
`define DCACHE_MSHR_W       3               // MSHR index.

// ==========================================================================
// Line geometry and id ranges
// ==========================================================================
`define DCACHE_LINE_BYTES   32              // Cache line size in bytes.
`define DCACHE_WORD_BYTES   4               // Uncached access size.
`define DCACHE_LINE_LEN     7               // Eight beats of one word.
`define DCACHE_UC_ID_BASE   8               // Ids 8 to 11 for uncached reads.
`define DCACHE_PF_ID_BASE   12              // Ids 12 to 15 for prefetches.
`define DCACHE_MEM_PORTS    3               // Miss, uncached, prefetch.

`endif
